/* logic/spi_tx_pkg.sv */
package spi_tx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Data width is fixed for the whole design
	localparam int BYTE_W = 8;

	// Half-period divider width
	localparam int DIV_W = 16;

	// Bit counter, enough to count the bits of one byte
	localparam int BIT_CNT_W = $clog2(BYTE_W);

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// One data byte as it travels from host to MOSI
	typedef logic [BYTE_W-1:0] spi_byte_t;

	// SCLK holds each level for div+1 clocks
	typedef logic [DIV_W-1:0] spi_div_t;

	// Level of arst_n that holds the design in reset
	localparam logic RST_ACTIVE = 1'b0;

endpackage

/* logic/spi_tx_fifo.sv */
`timescale 1ns/1ps

module spi_tx_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  host_req,
	input  spi_tx_pkg::spi_byte_t host_data,
	input  logic                  host_last,
	output logic                  host_ack,
	input  logic                  fifo_pop,
	output spi_tx_pkg::spi_byte_t fifo_data,
	output logic                  fifo_last,
	output logic                  fifo_empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	// Four-phase handshake tracking
	typedef enum logic [0:0] {
		HS_WAIT,
		HS_ACK
	} hs_state_t;

	hs_state_t hs_state;

	// Entry storage
	spi_tx_pkg::spi_byte_t mem_data [FIFO_DEPTH];
	logic                  mem_last [FIFO_DEPTH];

	// Pointers carry one extra wrap bit
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign fifo_empty = (wr_ptr == rd_ptr);

	// Accept a request only once per req/ack cycle, and only with space
	assign wr_en = (hs_state == HS_WAIT) && host_req && !full;
	assign rd_en = fifo_pop && !fifo_empty;

	assign host_ack = (hs_state == HS_ACK);

	////////////////////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			hs_state <= HS_WAIT;
		end else begin
			case (hs_state)
				HS_WAIT: begin
					if (wr_en) begin
						hs_state <= HS_ACK;
					end
				end
				HS_ACK: begin
					// Host has dropped req, close the cycle
					if (!host_req) begin
						hs_state <= HS_WAIT;
					end
				end
				default: hs_state <= HS_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_data[wr_ptr[AW-1:0]] <= host_data;
			mem_last[wr_ptr[AW-1:0]] <= host_last;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Head entry, valid while not empty
	assign fifo_data = mem_data[rd_ptr[AW-1:0]];
	assign fifo_last = mem_last[rd_ptr[AW-1:0]];

endmodule

/* logic/spi_tx_shift.sv */
`timescale 1ns/1ps

module spi_tx_shift (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  shift_en,
	input  spi_tx_pkg::spi_byte_t shift_data,
	input  spi_tx_pkg::spi_div_t  tx_div,
	output logic                  shift_cmpt,
	output logic                  sclk,
	output logic                  mosi
);

	typedef enum logic [0:0] {
		S_DOUT,
		S_CMPT
	} state_t;

	state_t state;

	spi_tx_pkg::spi_byte_t            shift_reg;
	logic [spi_tx_pkg::BIT_CNT_W-1:0] bit_cnt;
	spi_tx_pkg::spi_div_t             div_cnt;
	logic                             div_pulse;
	logic                             primed;

	logic bit_load;
	logic bit_next;
	logic bit_out;
	logic last_fall;

	// First pulse puts the MSB on MOSI and leaves SCLK low
	assign bit_load = (state == S_DOUT) && !primed && div_pulse;

	// Each SCLK fall but the last brings the next bit
	assign bit_next = (state == S_DOUT) && sclk && div_pulse && !(&bit_cnt);

	assign bit_out = bit_load || bit_next;

	// Eighth SCLK fall ends the byte
	assign last_fall = (state == S_DOUT) && (&bit_cnt) && sclk && div_pulse;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			state      <= S_DOUT;
			shift_cmpt <= 1'b0;
		end else if (!shift_en) begin
			state      <= S_DOUT;
			shift_cmpt <= 1'b0;
		end else begin
			case (state)
				S_DOUT: begin
					if (last_fall) begin
						state      <= S_CMPT;
						shift_cmpt <= 1'b1;
					end
				end
				// Hold completion until shift_en drops
				S_CMPT: begin
					shift_cmpt <= 1'b1;
				end
				default: state <= S_DOUT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Divider and SCLK
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			div_cnt   <= '0;
			div_pulse <= 1'b0;
			sclk      <= 1'b0;
			bit_cnt   <= '0;
			primed    <= 1'b0;
		end else if (!shift_en) begin
			div_cnt   <= '0;
			div_pulse <= 1'b0;
			sclk      <= 1'b0;
			bit_cnt   <= '0;
			primed    <= 1'b0;
		end else begin
			if (bit_load) begin
				primed <= 1'b1;
			end

			// SCLK runs once the MSB is out
			if (state == S_DOUT && div_pulse && primed) begin
				sclk <= !sclk;
				// Count a bit once its high phase ends
				if (sclk) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end

			// One pulse every div+1 clocks
			if (div_cnt >= tx_div) begin
				div_cnt   <= '0;
				div_pulse <= 1'b1;
			end else begin
				div_cnt   <= div_cnt + 1'b1;
				div_pulse <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// MSB first data path
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			mosi <= 1'b0;
		end else if (!shift_en) begin
			mosi <= 1'b0;
		end else if (bit_out) begin
			mosi <= shift_reg[spi_tx_pkg::BYTE_W-1];
		end
	end

	// Reload whenever idle and shift left as bits go out
	always_ff @(posedge clk) begin
		if (!shift_en) begin
			shift_reg <= shift_data;
		end else if (bit_out) begin
			shift_reg <= {shift_reg[spi_tx_pkg::BYTE_W-2:0], 1'b0};
		end
	end

endmodule

/* logic/spi_tx_ctrl.sv */
`timescale 1ns/1ps

module spi_tx_ctrl #(
	parameter int CS_GAP = 3
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  fifo_empty,
	input  spi_tx_pkg::spi_byte_t fifo_data,
	input  logic                  fifo_last,
	output logic                  fifo_pop,
	output logic                  shift_en,
	output spi_tx_pkg::spi_byte_t shift_data,
	input  logic                  shift_cmpt,
	output logic                  cs_n,
	output logic                  busy
);

	localparam int GAP_W = $clog2(CS_GAP + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_NEXT,
		ST_GAP
	} state_t;

	state_t state;

	logic             last_q;
	logic [GAP_W-1:0] gap_cnt;
	logic             byte_done;

	assign byte_done = (state == ST_SHIFT) && shift_cmpt;

	// Take the head entry when a frame starts or the previous byte of it ends
	assign fifo_pop = !fifo_empty && ((state == ST_IDLE) || (state == ST_NEXT) ||
		(byte_done && !last_q));

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			state    <= ST_IDLE;
			last_q   <= 1'b0;
			gap_cnt  <= '0;
			shift_en <= 1'b0;
			cs_n     <= 1'b1;
			busy     <= 1'b0;
		end else begin
			if (fifo_pop) begin
				last_q <= fifo_last;
			end

			case (state)
				ST_IDLE: begin
					if (fifo_pop) begin
						cs_n  <= 1'b0;
						busy  <= 1'b1;
						state <= ST_LOAD;
					end
				end
				// shift_en low for this clock so the serializer reloads
				ST_LOAD: begin
					shift_en <= 1'b1;
					state    <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (shift_cmpt) begin
						shift_en <= 1'b0;
						if (last_q) begin
							cs_n    <= 1'b1;
							busy    <= 1'b0;
							gap_cnt <= '0;
							state   <= ST_GAP;
						end else if (fifo_pop) begin
							state <= ST_LOAD;
						end else begin
							state <= ST_NEXT;
						end
					end
				end
				// Mid-frame underrun, cs_n stays low
				ST_NEXT: begin
					if (fifo_pop) begin
						state <= ST_LOAD;
					end
				end
				ST_GAP: begin
					if (gap_cnt == GAP_W'(CS_GAP - 1)) begin
						state <= ST_IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Byte handed to the serializer
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			shift_data <= fifo_data;
		end
	end

endmodule

/* logic/spi_tx_top.sv */
`timescale 1ns/1ps

module spi_tx_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int CS_GAP     = 3
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  host_req,
	input  spi_tx_pkg::spi_byte_t host_data,
	input  logic                  host_last,
	output logic                  host_ack,
	input  spi_tx_pkg::spi_div_t  tx_div,
	output logic                  sclk,
	output logic                  mosi,
	output logic                  cs_n,
	output logic                  busy
);

	// FIFO head
	logic                  fifo_empty;
	spi_tx_pkg::spi_byte_t fifo_data;
	logic                  fifo_last;
	logic                  fifo_pop;

	// Serializer control
	logic                  shift_en;
	spi_tx_pkg::spi_byte_t shift_data;
	logic                  shift_cmpt;

	spi_tx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.host_req   (host_req),
		.host_data  (host_data),
		.host_last  (host_last),
		.host_ack   (host_ack),
		.fifo_pop   (fifo_pop),
		.fifo_data  (fifo_data),
		.fifo_last  (fifo_last),
		.fifo_empty (fifo_empty)
	);

	spi_tx_ctrl #(
		.CS_GAP (CS_GAP)
	) ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_empty (fifo_empty),
		.fifo_data  (fifo_data),
		.fifo_last  (fifo_last),
		.fifo_pop   (fifo_pop),
		.shift_en   (shift_en),
		.shift_data (shift_data),
		.shift_cmpt (shift_cmpt),
		.cs_n       (cs_n),
		.busy       (busy)
	);

	spi_tx_shift shift_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.shift_en   (shift_en),
		.shift_data (shift_data),
		.tx_div     (tx_div),
		.shift_cmpt (shift_cmpt),
		.sclk       (sclk),
		.mosi       (mosi)
	);

endmodule

/* tests/spi_tx_sva.sv */
`timescale 1ns/1ps

module spi_tx_sva #(
	parameter int CS_GAP = 3
) (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 host_req,
	input logic                 host_ack,
	input spi_tx_pkg::spi_div_t tx_div,
	input logic                 shift_en,
	input logic                 sclk,
	input logic                 mosi,
	input logic                 cs_n
);

	// Flags raised by the action blocks below
	logic ack_rise_bad  = 1'b0;
	logic ack_fall_bad  = 1'b0;
	logic req_rise_bad  = 1'b0;
	logic sclk_idle_bad = 1'b0;
	logic mosi_bad      = 1'b0;
	logic high_len_bad  = 1'b0;
	logic low_len_bad   = 1'b0;
	logic gap_bad       = 1'b0;
	logic any_fired;

	logic        sclk_q;
	logic        fell_seen;
	logic [31:0] lvl_cnt;
	logic [31:0] cs_hi_cnt;
	logic [31:0] half_period;

	assign any_fired = ack_rise_bad | ack_fall_bad | req_rise_bad | sclk_idle_bad |
		mosi_bad | high_len_bad | low_len_bad | gap_bad;

	assign half_period = 32'(tx_div) + 32'd1;

	////////////////////////////////////////////////////////////////////////////
	// Level length counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (arst_n == spi_tx_pkg::RST_ACTIVE) begin
			sclk_q    <= 1'b0;
			fell_seen <= 1'b0;
			lvl_cnt   <= '0;
			cs_hi_cnt <= '0;
		end else begin
			sclk_q <= sclk;
			if (sclk != sclk_q) begin
				lvl_cnt <= 32'd1;
			end else begin
				lvl_cnt <= lvl_cnt + 32'd1;
			end
			// Low phases inside a byte start with a falling edge
			if (!shift_en) begin
				fell_seen <= 1'b0;
			end else if (sclk_q && !sclk) begin
				fell_seen <= 1'b1;
			end
			if (cs_n) begin
				cs_hi_cnt <= cs_hi_cnt + 32'd1;
			end else begin
				cs_hi_cnt <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////////////////////////////////////////

	ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(host_ack) |-> $past(host_req)) else begin
		ack_rise_bad = 1'b1;
		$error("host_ack rose without a pending request");
	end

	ack_drop_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		host_ack && !host_req |=> !host_ack) else begin
		ack_fall_bad = 1'b1;
		$error("host_ack stayed high after req was low");
	end

	req_not_during_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(host_req) |-> !host_ack) else begin
		req_rise_bad = 1'b1;
		$error("host_req rose while host_ack was high");
	end

	////////////////////////////////////////////////////////////////////////////
	// SPI side
	////////////////////////////////////////////////////////////////////////////

	sclk_idle_low: assert property (@(posedge clk) disable iff (!arst_n)
		cs_n |-> !sclk) else begin
		sclk_idle_bad = 1'b1;
		$error("sclk high while cs_n is high");
	end

	mosi_change_low: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(mosi) |-> !sclk) else begin
		mosi_bad = 1'b1;
		$error("mosi changed while sclk is high");
	end

	sclk_high_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(sclk) |-> lvl_cnt == half_period) else begin
		high_len_bad = 1'b1;
		$error("sclk high phase length differs from tx_div+1");
	end

	sclk_low_len: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(sclk) && fell_seen |-> lvl_cnt == half_period) else begin
		low_len_bad = 1'b1;
		$error("sclk low phase length differs from tx_div+1");
	end

	cs_gap_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(cs_n) |-> cs_hi_cnt >= 32'(CS_GAP)) else begin
		gap_bad = 1'b1;
		$error("cs_n gap between frames shorter than CS_GAP");
	end

endmodule

bind spi_tx_top spi_tx_sva #(
	.CS_GAP (CS_GAP)
) sva_i (
	.clk      (clk),
	.arst_n   (arst_n),
	.host_req (host_req),
	.host_ack (host_ack),
	.tx_div   (tx_div),
	.shift_en (shift_en),
	.sclk     (sclk),
	.mosi     (mosi),
	.cs_n     (cs_n)
);

/* tests/spi_tx_tb.sv */
`timescale 1ns/1ps

module spi_tx_tb;

	localparam int FIFO_DEPTH    = 4;
	localparam int CS_GAP        = 3;
	localparam int HS_TIMEOUT    = 4000;
	localparam int DRAIN_TIMEOUT = 40000;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic                  host_req;
	spi_tx_pkg::spi_byte_t host_data;
	logic                  host_last;
	logic                  host_ack;
	spi_tx_pkg::spi_div_t  tx_div;
	logic                  sclk;
	logic                  mosi;
	logic                  cs_n;
	logic                  busy;

	// Sent values still to be seen on the SPI side
	spi_tx_pkg::spi_byte_t exp_bytes [$];
	int                    exp_lens [$];

	string       test_name = "reset";
	logic [31:0] rng_state = 32'd62;

	// Capture model state
	logic                  sclk_prev = 1'b0;
	logic                  mosi_prev = 1'b0;
	logic                  cs_prev   = 1'b1;
	spi_tx_pkg::spi_byte_t cap_byte  = '0;
	int                    cap_bits  = 0;
	int                    frame_cnt = 0;

	spi_tx_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.CS_GAP     (CS_GAP)
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.host_req  (host_req),
		.host_data (host_data),
		.host_last (host_last),
		.host_ack  (host_ack),
		.tx_div    (tx_div),
		.sclk      (sclk),
		.mosi      (mosi),
		.cs_n      (cs_n),
		.busy      (busy)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
			test_name, what, expected, actual);
		$display("Errors found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("FAILURE in %s: %s", test_name, what);
		$display("Errors found");
		$fatal(1, "Stopped at the first failure");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Four-phase req/ack for one byte
	task automatic send_byte(input spi_tx_pkg::spi_byte_t data, input logic last);
		int cnt;
		cnt = 0;
		while (host_ack) begin
			@(posedge clk);
			#1;
			cnt++;
			if (cnt > HS_TIMEOUT) report_failure("host_ack did not drop before a new request");
		end
		exp_bytes.push_back(data);
		host_data = data;
		host_last = last;
		host_req  = 1'b1;
		cnt = 0;
		while (!host_ack) begin
			@(posedge clk);
			#1;
			cnt++;
			if (cnt > HS_TIMEOUT) report_failure("no host_ack for a pending request");
		end
		host_req = 1'b0;
		cnt = 0;
		while (host_ack) begin
			@(posedge clk);
			#1;
			cnt++;
			if (cnt > HS_TIMEOUT) report_failure("host_ack stuck high after req dropped");
		end
	endtask

	// Random bytes with the last flag on the final one
	task automatic send_frame(input int n);
		spi_tx_pkg::spi_byte_t b;
		exp_lens.push_back(n);
		for (int i = 0; i < n; i++) begin
			rng_state = xorshift32(rng_state);
			b = rng_state[7:0];
			send_byte(b, (i == n - 1));
		end
	endtask

	task automatic wait_drained();
		int cnt;
		cnt = 0;
		while (exp_lens.size() != 0 || !cs_n || busy) begin
			@(posedge clk);
			#1;
			cnt++;
			if (cnt > DRAIN_TIMEOUT) report_failure("frames did not finish in time");
		end
		assert (exp_bytes.size() == 0)
			else report_mismatch("bytes left uncaptured", 0, exp_bytes.size());
	endtask

	task automatic check_byte(input spi_tx_pkg::spi_byte_t got);
		spi_tx_pkg::spi_byte_t exp;
		if (exp_bytes.size() == 0) begin
			report_failure("byte captured with none expected");
		end else begin
			exp = exp_bytes.pop_front();
			assert (got == exp) else report_mismatch("captured byte", int'(exp), int'(got));
		end
	endtask

	task automatic check_frame_len(input int got);
		int exp;
		if (exp_lens.size() == 0) begin
			report_failure("cs_n window seen with no frame expected");
		end else begin
			exp = exp_lens.pop_front();
			assert (got == exp) else report_mismatch("frame length", exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// SPI capture model sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (arst_n) begin
			if (!cs_n) begin
				assert (busy) else report_mismatch("busy during cs_n low", 1, int'(busy));
				// A slave takes mosi as it was just before the rise
				if (sclk && !sclk_prev) begin
					cap_byte = {cap_byte[6:0], mosi_prev};
					cap_bits++;
					if (cap_bits == 8) begin
						check_byte(cap_byte);
						cap_bits = 0;
						frame_cnt++;
					end
				end
			end
			// Frame ends when cs_n rises
			if (cs_n && !cs_prev) begin
				assert (cap_bits == 0) else report_mismatch("bits at frame end", 0, cap_bits);
				check_frame_len(frame_cnt);
				frame_cnt = 0;
			end
			assert (!dut_i.sva_i.any_fired) else report_failure("a bound protocol assertion fired");
		end
		sclk_prev = sclk;
		mosi_prev = mosi;
		cs_prev   = cs_n;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		arst_n    = 1'b0;
		host_req  = 1'b0;
		host_data = '0;
		host_last = 1'b0;
		tx_div    = '0;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		assert (cs_n === 1'b1) else report_mismatch("cs_n after reset", 1, int'(cs_n));
		assert (sclk === 1'b0) else report_mismatch("sclk after reset", 0, int'(sclk));
		assert (mosi === 1'b0) else report_mismatch("mosi after reset", 0, int'(mosi));
		assert (busy === 1'b0) else report_mismatch("busy after reset", 0, int'(busy));
		assert (host_ack === 1'b0) else report_mismatch("ack after reset", 0, int'(host_ack));

		// Asymmetric pattern shows bit order
		test_name = "single_byte";
		tx_div    = 16'd0;
		exp_lens.push_back(1);
		send_byte(8'hD2, 1'b1);
		wait_drained();

		test_name = "multi_byte";
		send_frame(5);
		wait_drained();

		test_name = "divider";
		tx_div    = 16'd3;
		send_frame(3);
		wait_drained();

		// Host outruns the serializer so the FIFO fills
		test_name = "back_pressure";
		tx_div    = 16'd5;
		send_frame(FIFO_DEPTH + 3);
		wait_drained();

		test_name = "frame_gap";
		tx_div    = 16'd1;
		send_frame(2);
		send_frame(3);
		send_frame(1);
		wait_drained();

		if (!dut_i.sva_i.any_fired) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Bound protocol assertions fired");
		end
	end

endmodule

/* src.f */
logic/spi_tx_pkg.sv
logic/spi_tx_fifo.sv
logic/spi_tx_shift.sv
logic/spi_tx_ctrl.sv
logic/spi_tx_top.sv
tests/spi_tx_sva.sv
tests/spi_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module spi_tx_tb -f src.f --Mdir obj_dir -o spi_tx_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit "$build_status"
fi

./obj_dir/spi_tx_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
	echo "Simulation failed with status $run_status"
	exit "$run_status"
fi

echo "Simulation finished with status 0"
exit 0
